// File: hdl/issue_pkg.sv
`default_nettype none

package issue_pkg;

  localparam int queue_depth = 8;
  localparam int qptr_bits = $clog2(queue_depth);
  localparam int xlen = 32;

  // apb register map
  localparam logic [7:0] addr_ctrl = 8'h00;
  localparam logic [7:0] addr_issued = 8'h04;
  localparam logic [7:0] addr_pairs = 8'h08;
  localparam logic [7:0] addr_stalls = 8'h0c;

  // rv32 major opcodes
  localparam logic [6:0] opc_lui = 7'b0110111;
  localparam logic [6:0] opc_auipc = 7'b0010111;
  localparam logic [6:0] opc_jal = 7'b1101111;
  localparam logic [6:0] opc_jalr = 7'b1100111;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_load = 7'b0000011;
  localparam logic [6:0] opc_store = 7'b0100011;
  localparam logic [6:0] opc_opimm = 7'b0010011;
  localparam logic [6:0] opc_op = 7'b0110011;
  localparam logic [6:0] opc_system = 7'b1110011;
  localparam logic [6:0] opc_fence = 7'b0001111;
  localparam logic [6:0] funct7_muldiv = 7'b0000001;

  typedef struct packed {
    logic alu;
    logic lui;
    logic auipc;
    logic jal;
    logic jalr;
    logic branch;
    logic load;
    logic store;
    logic mult;
    logic csreg;
    logic fence;
    logic valid;
    logic wren;
    logic rden1;
    logic rden2;
  } op_flags_t;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [31:0] instr;
    logic [xlen-1:0] imm;
    logic [4:0] waddr;
    logic [4:0] raddr1;
    logic [4:0] raddr2;
    op_flags_t op;
  } decoded_t;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [31:0] instr0;
    logic [31:0] instr1;
    logic valid0;
    logic valid1;
  } fetch_pair_t;

  // instr0 is the older one
  typedef struct packed {
    decoded_t instr0;
    decoded_t instr1;
  } decoded_pair_t;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [31:0] instr;
    logic [xlen-1:0] imm;
    logic [4:0] waddr;
    logic [4:0] raddr1;
    logic [4:0] raddr2;
    op_flags_t op;
  } issue_slot_t;

  typedef struct packed {
    issue_slot_t slot0;
    issue_slot_t slot1;
  } issue_pair_t;

  localparam decoded_t init_decoded = '0;
  localparam issue_slot_t init_slot = '0;

  function automatic logic is_basic(op_flags_t op);
    return op.alu | op.lui | op.auipc | op.jal | op.jalr | op.branch;
  endfunction

  function automatic logic is_complex(op_flags_t op);
    return op.load | op.store | op.mult | op.csreg | op.fence;
  endfunction

endpackage

`default_nettype wire

// File: hdl/instr_decode.sv
`timescale 1ns/10ps
`default_nettype none

module instr_decode (
  input  issue_pkg::fetch_pair_t fetch,
  output issue_pkg::decoded_pair_t decoded
);
  import issue_pkg::*;

  function automatic decoded_t decode_word(logic [31:0] word, logic [xlen-1:0] pc,
                                           logic valid);
    decoded_t d;
    logic [2:0] funct3;
    d = init_decoded;
    funct3 = word[14:12];
    if (valid) begin
      d.pc = pc;
      d.instr = word;
      d.waddr = word[11:7];
      d.raddr1 = word[19:15];
      d.raddr2 = word[24:20];
      d.op.valid = 1'b1;
      case (word[6:0])
        opc_lui: begin
          d.op.lui = 1'b1;
          d.op.wren = 1'b1;
          d.imm = {word[31:12], 12'b0};
        end
        opc_auipc: begin
          d.op.auipc = 1'b1;
          d.op.wren = 1'b1;
          d.imm = {word[31:12], 12'b0};
        end
        opc_jal: begin
          d.op.jal = 1'b1;
          d.op.wren = 1'b1;
          d.imm = {{11{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};
        end
        opc_jalr: begin
          d.op.jalr = 1'b1;
          d.op.wren = 1'b1;
          d.op.rden1 = 1'b1;
          d.imm = {{20{word[31]}}, word[31:20]};
        end
        opc_branch: begin
          d.op.branch = 1'b1;
          d.op.rden1 = 1'b1;
          d.op.rden2 = 1'b1;
          d.imm = {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
        end
        opc_load: begin
          d.op.load = 1'b1;
          d.op.wren = 1'b1;
          d.op.rden1 = 1'b1;
          d.imm = {{20{word[31]}}, word[31:20]};
        end
        opc_store: begin
          d.op.store = 1'b1;
          d.op.rden1 = 1'b1;
          d.op.rden2 = 1'b1;
          d.imm = {{20{word[31]}}, word[31:25], word[11:7]};
        end
        opc_opimm: begin
          d.op.alu = 1'b1;
          d.op.wren = 1'b1;
          d.op.rden1 = 1'b1;
          d.imm = {{20{word[31]}}, word[31:20]};
        end
        opc_op: begin
          d.op.wren = 1'b1;
          d.op.rden1 = 1'b1;
          d.op.rden2 = 1'b1;
          // divide forms carry no class and issue alone
          if (word[31:25] == funct7_muldiv) begin
            d.op.mult = !funct3[2];
          end else begin
            d.op.alu = 1'b1;
          end
        end
        opc_system: begin
          d.op.csreg = (funct3 != 3'd0);
          d.op.wren = d.op.csreg;
          d.op.rden1 = d.op.csreg && !funct3[2];
          d.imm = {20'b0, word[31:20]};
        end
        opc_fence: begin
          d.op.fence = 1'b1;
        end
        default: begin
        end
      endcase
      // x0 never creates a dependency
      d.op.wren = d.op.wren && (d.waddr != 5'd0);
    end
    return d;
  endfunction

  always_comb begin
    decoded.instr0 = decode_word(fetch.instr0, fetch.pc, fetch.valid0);
    decoded.instr1 = decode_word(fetch.instr1, fetch.pc + xlen'(4), fetch.valid1);
  end

endmodule

`default_nettype wire

// File: hdl/pipe_stage.sv
`timescale 1ns/10ps
`default_nettype none

module pipe_stage #(
  parameter type payload_t = logic
) (
  input  logic clock,
  input  logic reset,
  input  logic hold,
  input  logic flush,
  input  payload_t d,
  output payload_t q
);

  // all-zero payload clears every valid flag
  always_ff @(posedge clock) begin
    if (!reset || flush) begin
      q <= '0;
    end else if (!hold) begin
      q <= d;
    end
  end

endmodule

`default_nettype wire

// File: hdl/issue_queue.sv
`timescale 1ns/10ps
`default_nettype none

module issue_queue (
  input  logic clock,
  input  logic reset,
  input  logic flush,
  input  logic exec_stall,
  input  logic dual_enable,
  input  issue_pkg::decoded_pair_t in_pair,
  output issue_pkg::issue_pair_t out_pair,
  output logic stall,
  output logic [1:0] issued_count
);
  import issue_pkg::*;

  typedef struct packed {
    logic [qptr_bits-1:0] wptr;
    logic [qptr_bits-1:0] rptr;
    logic [qptr_bits:0] count;
    logic stall;
  } queue_state_t;

  decoded_t buffer [queue_depth];
  decoded_t buffer_next [queue_depth];
  queue_state_t r;
  queue_state_t rin;
  decoded_t head0;
  decoded_t head1;
  logic raw;
  logic [1:0] pass;

  always_comb begin
    buffer_next = buffer;
    rin = r;

    if (flush) begin
      rin = '0;
    end else if (!r.stall) begin
      if (in_pair.instr0.op.valid) begin
        buffer_next[rin.wptr] = in_pair.instr0;
        rin.wptr = rin.wptr + 1'b1;
        rin.count = rin.count + 1'b1;
      end
      if (in_pair.instr1.op.valid) begin
        buffer_next[rin.wptr] = in_pair.instr1;
        rin.wptr = rin.wptr + 1'b1;
        rin.count = rin.count + 1'b1;
      end
    end

    // oldest two entries, including ones written this cycle
    head0 = (rin.count > 0) ? buffer_next[rin.rptr] : init_decoded;
    head1 = (rin.count > 1) ? buffer_next[rin.rptr + 1'b1] : init_decoded;

    // younger reads what the older writes
    raw = head0.op.wren &&
          ((head1.op.rden1 && (head1.raddr1 == head0.waddr)) ||
           (head1.op.rden2 && (head1.raddr2 == head0.waddr)));

    if (exec_stall) begin
      pass = 2'd0;
    end else if (dual_enable && (is_basic(head0.op) || is_complex(head0.op)) &&
                 is_basic(head1.op) && !raw) begin
      pass = 2'd2;
    end else begin
      pass = 2'd1;
    end

    if (rin.count < pass) begin
      pass = rin.count[1:0];
    end

    rin.rptr = rin.rptr + qptr_bits'(pass);
    rin.count = rin.count - (qptr_bits + 1)'(pass);
    rin.stall = (rin.count > queue_depth / 2);
  end

  always_comb begin
    out_pair.slot0 = (pass > 2'd0) ? issue_slot_t'(head0) : init_slot;
    out_pair.slot1 = (pass > 2'd1) ? issue_slot_t'(head1) : init_slot;
  end

  assign stall = r.stall;
  assign issued_count = pass;

  always_ff @(posedge clock) begin
    buffer <= buffer_next;
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      r <= '0;
    end else begin
      r <= rin;
    end
  end

endmodule

`default_nettype wire

// File: hdl/issue_csr_apb.sv
`timescale 1ns/10ps
`default_nettype none

module issue_csr_apb (
  input  logic clock,
  input  logic reset,
  input  logic psel,
  input  logic penable,
  input  logic pwrite,
  input  logic [7:0] paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic pready,
  output logic pslverr,
  input  logic [1:0] issued_count,
  input  logic stall,
  output logic dual_enable
);
  import issue_pkg::*;

  typedef struct packed {
    logic [xlen-1:0] issued;
    logic [xlen-1:0] pairs;
    logic [xlen-1:0] stalls;
  } counters_t;

  counters_t counts;
  logic access;
  logic write;
  logic mapped;

  // access phase of the two-cycle transfer
  assign access = psel && penable;
  assign write = access && pwrite;

  always_comb begin
    mapped = 1'b1;
    case (paddr)
      addr_ctrl: prdata = {31'b0, dual_enable};
      addr_issued: prdata = counts.issued;
      addr_pairs: prdata = counts.pairs;
      addr_stalls: prdata = counts.stalls;
      default: begin
        prdata = '0;
        mapped = 1'b0;
      end
    endcase
  end

  assign pready = 1'b1;
  assign pslverr = access && !mapped;

  always_ff @(posedge clock) begin
    if (!reset) begin
      dual_enable <= 1'b1;
      counts <= '0;
    end else begin
      if (write && (paddr == addr_ctrl)) begin
        dual_enable <= pwdata[0];
      end
      // any write to the issued count clears all three
      if (write && (paddr == addr_issued)) begin
        counts <= '0;
      end else begin
        counts.issued <= counts.issued + xlen'(issued_count);
        if (issued_count == 2'd2) begin
          counts.pairs <= counts.pairs + 1'b1;
        end
        if (stall) begin
          counts.stalls <= counts.stalls + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/issue_top.sv
`timescale 1ns/10ps
`default_nettype none

module issue_top (
  input  logic clock,
  input  logic reset,
  input  logic flush,
  input  logic exec_stall,
  input  issue_pkg::fetch_pair_t fetch,
  output logic fetch_ready,
  output issue_pkg::issue_pair_t issue,
  input  logic psel,
  input  logic penable,
  input  logic pwrite,
  input  logic [7:0] paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic pready,
  output logic pslverr
);
  import issue_pkg::*;

  decoded_pair_t decoded_d;
  decoded_pair_t decoded_q;
  issue_pair_t queue_out;
  logic stall;
  logic dual_enable;
  logic [1:0] issued_count;

  assign fetch_ready = !stall;

  instr_decode u_decode (
    .fetch   (fetch),
    .decoded (decoded_d)
  );

  pipe_stage #(
    .payload_t (decoded_pair_t)
  ) decode_reg (
    .clock (clock),
    .reset (reset),
    .hold  (stall),
    .flush (flush),
    .d     (decoded_d),
    .q     (decoded_q)
  );

  issue_queue u_queue (
    .clock        (clock),
    .reset        (reset),
    .flush        (flush),
    .exec_stall   (exec_stall),
    .dual_enable  (dual_enable),
    .in_pair      (decoded_q),
    .out_pair     (queue_out),
    .stall        (stall),
    .issued_count (issued_count)
  );

  pipe_stage #(
    .payload_t (issue_pair_t)
  ) issue_reg (
    .clock (clock),
    .reset (reset),
    .hold  (exec_stall),
    .flush (flush),
    .d     (queue_out),
    .q     (issue)
  );

  issue_csr_apb u_csr (
    .clock        (clock),
    .reset        (reset),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .prdata       (prdata),
    .pready       (pready),
    .pslverr      (pslverr),
    .issued_count (issued_count),
    .stall        (stall),
    .dual_enable  (dual_enable)
  );

endmodule

`default_nettype wire

// File: testbench/tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
  output logic clock,
  output logic reset
);

  localparam int half_period = 20;

  initial begin
    clock = 1'b0;
    forever #(half_period) clock = ~clock;
  end

  // active low, held for four rising edges
  initial begin
    reset = 1'b0;
    repeat (4) @(posedge clock);
    reset <= 1'b1;
  end

endmodule

`default_nettype wire

// File: testbench/issue_assert.sv
`timescale 1ns/10ps
`default_nettype none

module issue_assert (
  input logic clock,
  input logic reset,
  input logic stall,
  input logic dual_enable,
  input logic [1:0] issued_count,
  input issue_pkg::issue_pair_t out_pair
);

  logic raw_pair;

  // younger slot reads what the older slot writes
  assign raw_pair = out_pair.slot0.op.wren &&
    ((out_pair.slot1.op.rden1 && (out_pair.slot1.raddr1 == out_pair.slot0.waddr)) ||
     (out_pair.slot1.op.rden2 && (out_pair.slot1.raddr2 == out_pair.slot0.waddr)));

  stall_after_reset: assert property (@(posedge clock) !reset |=> !stall)
    else $error("stall high in the cycle after reset");

  no_raw_pair: assert property (@(posedge clock) disable iff (!reset)
    out_pair.slot1.op.valid |-> !raw_pair)
    else $error("pair issued with a read-after-write match");

  dual_needs_enable: assert property (@(posedge clock) disable iff (!reset)
    (issued_count == 2'd2) |-> dual_enable)
    else $error("two instructions issued while dual issue is off");

endmodule

bind issue_queue issue_assert u_issue_assert (
  .clock        (clock),
  .reset        (reset),
  .stall        (stall),
  .dual_enable  (dual_enable),
  .issued_count (issued_count),
  .out_pair     (out_pair)
);

`default_nettype wire

// File: testbench/tb_issue.sv
`timescale 1ns/10ps
`default_nettype none

module tb_issue;
  import issue_pkg::*;

  localparam int kind_alui = 0;
  localparam int kind_alur = 1;
  localparam int kind_load = 2;
  localparam int kind_store = 3;
  localparam int clock_period = 40;
  localparam int step_limit = 40;
  // rough cycle budget of each test
  localparam int reset_cycles = 20;
  localparam int alu_cycles = 40;
  localparam int mixed_cycles = 60;
  localparam int burst_cycles = 100;
  localparam int flush_cycles = 80;
  localparam int csr_cycles = 120;
  localparam int watchdog_ns = 2 * clock_period *
    (reset_cycles + alu_cycles + mixed_cycles + burst_cycles + flush_cycles + csr_cycles);

  logic clock;
  logic reset;
  logic flush;
  logic exec_stall;
  fetch_pair_t fetch;
  logic fetch_ready;
  issue_pair_t issue;
  logic psel;
  logic penable;
  logic pwrite;
  logic [7:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic pready;
  logic pslverr;

  logic [31:0] lfsr_state = 32'd69991;
  issue_slot_t expected [$];
  logic [xlen-1:0] next_pc;
  logic dual_on;
  logic ready_seen;
  logic exec_seen;
  int errors;
  int tests_run;
  int failed_tests;
  int issued_seen;
  int pairs_seen;
  int stalls_seen;

  tb_clock u_clock (
    .clock (clock),
    .reset (reset)
  );

  issue_top DUT (
    .clock       (clock),
    .reset       (reset),
    .flush       (flush),
    .exec_stall  (exec_stall),
    .fetch       (fetch),
    .fetch_ready (fetch_ready),
    .issue       (issue),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr)
  );

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] lfsr_bits(int n);
    logic [31:0] v;
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  function automatic logic [4:0] rand_reg();
    logic [4:0] r;
    r = 5'(lfsr_bits(5));
    if (r == 5'd0) begin
      r = 5'd1;
    end
    return r;
  endfunction

  function automatic logic [4:0] indep_reg(logic [4:0] rd);
    logic [4:0] r;
    r = rand_reg();
    if (r == rd) begin
      r = rd ^ 5'd1;
    end
    return r;
  endfunction

  function automatic logic [11:0] rand_imm();
    return 12'(lfsr_bits(12));
  endfunction

  // expected slot built from the rv32 encoding
  function automatic issue_slot_t make_instr(int kind, logic [4:0] rd, logic [4:0] rs1,
                                             logic [4:0] rs2, logic [11:0] imm);
    issue_slot_t s;
    s = init_slot;
    case (kind)
      kind_alui: s.instr = {imm, rs1, 3'b000, rd, 7'b0010011};
      kind_alur: s.instr = {7'b0, rs2, rs1, 3'b000, rd, 7'b0110011};
      kind_load: s.instr = {imm, rs1, 3'b010, rd, 7'b0000011};
      default: s.instr = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endcase
    s.waddr = s.instr[11:7];
    s.raddr1 = s.instr[19:15];
    s.raddr2 = s.instr[24:20];
    s.imm = (kind == kind_alur) ? '0 : {{20{imm[11]}}, imm};
    s.op.valid = 1'b1;
    s.op.alu = (kind == kind_alui) || (kind == kind_alur);
    s.op.load = (kind == kind_load);
    s.op.store = (kind == kind_store);
    s.op.wren = (kind != kind_store) && (s.waddr != 5'd0);
    s.op.rden1 = 1'b1;
    s.op.rden2 = (kind == kind_alur) || (kind == kind_store);
    return s;
  endfunction

  function automatic issue_slot_t rand_instr();
    int kind;
    kind = int'(lfsr_bits(2)) % 3;
    return make_instr(kind, rand_reg(), rand_reg(), rand_reg(), rand_imm());
  endfunction

  function automatic logic can_pair(issue_slot_t a, issue_slot_t b);
    logic basic_a;
    logic basic_b;
    logic complex_a;
    logic raw;
    basic_a = a.op.alu | a.op.lui | a.op.auipc | a.op.jal | a.op.jalr | a.op.branch;
    basic_b = b.op.alu | b.op.lui | b.op.auipc | b.op.jal | b.op.jalr | b.op.branch;
    complex_a = a.op.load | a.op.store | a.op.mult | a.op.csreg | a.op.fence;
    raw = a.op.wren && ((b.op.rden1 && (b.raddr1 == a.waddr)) ||
                        (b.op.rden2 && (b.raddr2 == a.waddr)));
    return (basic_a || complex_a) && basic_b && !raw;
  endfunction

  task automatic check_slot(issue_slot_t got, issue_slot_t exp, string what);
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s at pc %h, got %h, expected %h",
               $time, what, exp.pc, got, exp);
    end
  endtask

  task automatic check_word(logic [31:0] got, logic [31:0] exp, string what);
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic take_slot(issue_slot_t got);
    issue_slot_t exp;
    if (expected.size() == 0) begin
      errors++;
      $display("instruction %h issued at %0t although none was outstanding",
               got.instr, $time);
    end else begin
      exp = expected.pop_front();
      check_slot(got, exp, "issued slot");
      issued_seen++;
    end
  endtask

  // issue_reg only loads when exec_stall was low before the edge
  always @(negedge clock) begin
    if (reset && !exec_seen && issue.slot0.op.valid) begin
      if (issue.slot1.op.valid) begin
        pairs_seen++;
        if (expected.size() < 2 || !dual_on || !can_pair(expected[0], expected[1])) begin
          errors++;
          $display("pair issued at %0t that the pairing rule forbids", $time);
        end
      end
      take_slot(issue.slot0);
      if (issue.slot1.op.valid) begin
        take_slot(issue.slot1);
      end
    end else if (reset && !exec_seen && issue.slot1.op.valid) begin
      errors++;
      $display("slot 1 valid with slot 0 empty at %0t", $time);
    end
    // each cycle with fetch held off is one stall cycle
    if (reset && !fetch_ready) begin
      stalls_seen++;
    end
    exec_seen = exec_stall;
    ready_seen = fetch_ready;
  end

  task automatic send_pair(issue_slot_t a, issue_slot_t b);
    int waited;
    a.pc = next_pc;
    b.pc = next_pc + 32'd4;
    fetch.pc <= next_pc;
    fetch.instr0 <= a.instr;
    fetch.instr1 <= b.instr;
    fetch.valid0 <= 1'b1;
    fetch.valid1 <= 1'b1;
    next_pc = next_pc + 32'd8;
    expected.push_back(a);
    expected.push_back(b);
    waited = 0;
    do begin
      @(posedge clock);
      waited++;
    end while (!ready_seen && waited < step_limit);
    if (!ready_seen) begin
      errors++;
      $display("fetch pair at pc %h was never accepted", a.pc);
    end
  endtask

  task automatic idle_fetch();
    fetch.valid0 <= 1'b0;
    fetch.valid1 <= 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (expected.size() != 0 && waited < step_limit) begin
      @(posedge clock);
      waited++;
    end
    if (expected.size() != 0) begin
      errors++;
      $display("%0d instructions never issued by %0t", expected.size(), $time);
    end
    repeat (2) @(posedge clock);
  endtask

  task automatic run_pair(issue_slot_t a, issue_slot_t b, int exp_pairs);
    int start;
    start = pairs_seen;
    send_pair(a, b);
    idle_fetch();
    wait_drain();
    check_word(32'(pairs_seen - start), 32'(exp_pairs), "pairs issued");
  endtask

  task automatic make_indep_pair(output issue_slot_t a, output issue_slot_t b);
    logic [4:0] rd;
    rd = rand_reg();
    a = make_instr(kind_alui, rd, rand_reg(), 5'd0, rand_imm());
    b = make_instr(kind_alur, rand_reg(), indep_reg(rd), indep_reg(rd), 12'd0);
  endtask

  task automatic wait_pready();
    int waited;
    waited = 0;
    @(negedge clock);
    while (!pready && waited < step_limit) begin
      @(negedge clock);
      waited++;
    end
    if (!pready) begin
      errors++;
      $display("pready stayed low at %0t", $time);
    end
  endtask

  task automatic apb_write(logic [7:0] addr, logic [31:0] data);
    psel <= 1'b1;
    penable <= 1'b0;
    pwrite <= 1'b1;
    paddr <= addr;
    pwdata <= data;
    @(posedge clock);
    penable <= 1'b1;
    wait_pready();
    @(posedge clock);
    psel <= 1'b0;
    penable <= 1'b0;
    pwrite <= 1'b0;
  endtask

  task automatic apb_read(logic [7:0] addr, output logic [31:0] data, output logic err);
    psel <= 1'b1;
    penable <= 1'b0;
    pwrite <= 1'b0;
    paddr <= addr;
    @(posedge clock);
    penable <= 1'b1;
    wait_pready();
    data = prdata;
    err = pslverr;
    @(posedge clock);
    psel <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic read_check(logic [7:0] addr, logic [31:0] exp, string what);
    logic [31:0] data;
    logic err;
    apb_read(addr, data, err);
    check_word(data, exp, what);
    check_word(32'(err), 32'd0, "pslverr on a mapped address");
  endtask

  task automatic report_test(string name, int errors_before);
    tests_run++;
    if (errors > errors_before) begin
      failed_tests++;
      $display("test %s: %0d errors", name, errors - errors_before);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  task automatic test_reset();
    check_word(32'(fetch_ready), 32'd1, "fetch_ready after reset");
    check_slot(issue.slot0, init_slot, "slot 0 after reset");
    check_slot(issue.slot1, init_slot, "slot 1 after reset");
    read_check(addr_ctrl, 32'd1, "ctrl after reset");
    read_check(addr_issued, 32'd0, "issued count after reset");
    read_check(addr_pairs, 32'd0, "pair count after reset");
    read_check(addr_stalls, 32'd0, "stall count after reset");
  endtask

  task automatic test_alu_pairs();
    issue_slot_t a;
    issue_slot_t b;
    logic [4:0] rd;
    make_indep_pair(a, b);
    run_pair(a, b, 1);
    // younger reads the older destination
    rd = rand_reg();
    a = make_instr(kind_alur, rd, rand_reg(), rand_reg(), 12'd0);
    b = make_instr(kind_alui, rand_reg(), rd, 5'd0, rand_imm());
    run_pair(a, b, 0);
  endtask

  task automatic test_mixed_pairs();
    issue_slot_t a;
    issue_slot_t b;
    logic [4:0] rd;
    rd = rand_reg();
    a = make_instr(kind_load, rd, rand_reg(), 5'd0, rand_imm());
    b = make_instr(kind_alui, rand_reg(), indep_reg(rd), 5'd0, rand_imm());
    run_pair(a, b, 1);
    rd = rand_reg();
    a = make_instr(kind_alui, rd, rand_reg(), 5'd0, rand_imm());
    b = make_instr(kind_load, rand_reg(), indep_reg(rd), 5'd0, rand_imm());
    run_pair(a, b, 0);
    rd = rand_reg();
    a = make_instr(kind_load, rd, rand_reg(), 5'd0, rand_imm());
    b = make_instr(kind_store, 5'd0, indep_reg(rd), indep_reg(rd), rand_imm());
    run_pair(a, b, 0);
  endtask

  task automatic test_burst();
    logic saw_low;
    int waited;
    int k;
    saw_low = 1'b0;
    waited = 0;
    exec_stall <= 1'b1;
    fork
      begin
        for (k = 0; k < 6; k++) begin
          send_pair(rand_instr(), rand_instr());
        end
        idle_fetch();
      end
      begin
        while (!saw_low && waited < step_limit) begin
          @(negedge clock);
          saw_low = !fetch_ready;
          waited++;
        end
        repeat (3) @(posedge clock);
        exec_stall <= 1'b0;
      end
    join
    if (!saw_low) begin
      errors++;
      $display("fetch_ready never dropped while execute was stalled");
    end
    wait_drain();
  endtask

  task automatic test_flush();
    int start;
    exec_stall <= 1'b1;
    send_pair(rand_instr(), rand_instr());
    send_pair(rand_instr(), rand_instr());
    idle_fetch();
    flush <= 1'b1;
    @(posedge clock);
    flush <= 1'b0;
    exec_stall <= 1'b0;
    expected.delete();
    start = issued_seen;
    send_pair(rand_instr(), rand_instr());
    send_pair(rand_instr(), rand_instr());
    idle_fetch();
    wait_drain();
    check_word(32'(issued_seen - start), 32'd4, "instructions issued after flush");
  endtask

  task automatic test_csr();
    issue_slot_t a;
    issue_slot_t b;
    logic [31:0] data;
    logic err;
    apb_write(addr_ctrl, 32'd0);
    dual_on = 1'b0;
    make_indep_pair(a, b);
    run_pair(a, b, 0);
    make_indep_pair(a, b);
    run_pair(a, b, 0);
    apb_write(addr_ctrl, 32'd1);
    dual_on = 1'b1;
    make_indep_pair(a, b);
    run_pair(a, b, 1);
    // counts since reset, stalls come from the burst
    read_check(addr_issued, 32'(issued_seen), "issued count");
    read_check(addr_pairs, 32'(pairs_seen), "pair count");
    read_check(addr_stalls, 32'(stalls_seen), "stall count");
    read_check(addr_ctrl, 32'd1, "ctrl");
    apb_write(addr_issued, 32'hffff_ffff);
    read_check(addr_issued, 32'd0, "issued count after clear");
    read_check(addr_pairs, 32'd0, "pair count after clear");
    read_check(addr_stalls, 32'd0, "stall count after clear");
    apb_read(8'h20, data, err);
    check_word(32'(err), 32'd1, "pslverr on unmapped address");
  endtask

  initial begin
    int start;
    flush = 1'b0;
    exec_stall = 1'b0;
    fetch = '0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    next_pc = 32'h0000_1000;
    dual_on = 1'b1;
    ready_seen = 1'b0;
    exec_seen = 1'b1;
    errors = 0;
    tests_run = 0;
    failed_tests = 0;
    issued_seen = 0;
    pairs_seen = 0;
    stalls_seen = 0;
    @(posedge reset);
    @(posedge clock);
    start = errors;
    test_reset();
    report_test("reset values", start);
    start = errors;
    test_alu_pairs();
    report_test("alu pairing", start);
    start = errors;
    test_mixed_pairs();
    report_test("load and store pairing", start);
    start = errors;
    test_burst();
    report_test("burst with execute stall", start);
    start = errors;
    test_flush();
    report_test("flush", start);
    start = errors;
    test_csr();
    report_test("apb control and counters", start);
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, failed_tests, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin
    #(watchdog_ns);
    $display("watchdog expired after %0d ns before the tests finished", watchdog_ns);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
hdl/issue_pkg.sv
hdl/instr_decode.sv
hdl/pipe_stage.sv
hdl/issue_queue.sv
hdl/issue_csr_apb.sv
hdl/issue_top.sv
testbench/tb_clock.sv
testbench/issue_assert.sv
testbench/tb_issue.sv

// File: Makefile
SIM      := verilator
TOP      := tb_issue
FLIST    := flist.f
SIMFLAGS := --binary --timing --assert -Wno-fatal --top-module $(TOP)
BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
LOG      := sim.log
PASS_MSG := === PASS ===
SOURCES  := $(shell grep -v '^+' $(FLIST))

.PHONY: all run check clean

all: check

$(BIN): $(SOURCES) $(FLIST)
	$(SIM) $(SIMFLAGS) -f $(FLIST) --Mdir $(BUILD) -o V$(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

check: run
	@echo "simulation log $(LOG) holds the pass message"

clean:
	rm -rf $(BUILD) $(LOG)
